// ==== run_sim.sh ====
#!/bin/sh
# Builds the SFP management testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -j 0 --top-module sfp_mgmt_tb -f sources.f

./obj_dir/Vsfp_mgmt_tb > "$LOG" 2>&1

cat "$LOG"

if grep -q "Test failed" "$LOG"; then
  echo "Simulation reported a failure, see $LOG"
  exit 1
fi

if ! grep -q "Test passed" "$LOG"; then
  echo "Simulation ended without a result, see $LOG"
  exit 1
fi

echo "Simulation finished cleanly"

// ==== source/sfp_cage_regs.sv ====
// Per-cage pin synchronisers, I2C and transceiver GPIO register blocks and open-drain drive
module sfp_cage_regs #(
  parameter int CAGE_INDEX = 0
) (
  input  logic                          clk,
  input  logic                          rst,
  input  sfp_mgmt_pkg::cage_access_t    access,
  input  sfp_mgmt_pkg::cage_pins_in_t   pins_in,
  output sfp_mgmt_pkg::cage_pins_out_t  pins_out,
  output sfp_mgmt_pkg::reg_rsp_t        rsp,
  output sfp_mgmt_pkg::cage_status_t    status
);

  // Header chain pointers for this cage
  localparam logic [sfp_mgmt_pkg::DATA_WIDTH-1:0] I2C_BASE =
    sfp_mgmt_pkg::RB_BASE_ADDR + CAGE_INDEX * sfp_mgmt_pkg::CAGE_STRIDE;
  localparam logic [sfp_mgmt_pkg::DATA_WIDTH-1:0] GPIO_BASE =
    I2C_BASE + sfp_mgmt_pkg::GPIO_BLOCK_OFFSET;
  // Last cage ends the chain
  localparam logic [sfp_mgmt_pkg::DATA_WIDTH-1:0] NEXT_CAGE_BASE =
    (CAGE_INDEX == sfp_mgmt_pkg::NUM_CAGES - 1) ? '0 : I2C_BASE + sfp_mgmt_pkg::CAGE_STRIDE;

  sfp_mgmt_pkg::cage_pins_in_t         pins_meta;
  sfp_mgmt_pkg::cage_pins_in_t         pins_sync;
  logic                                scl_out;
  logic                                sda_out;
  logic                                tx_disable;
  logic                                wr_hit;
  logic                                rd_hit;
  logic [sfp_mgmt_pkg::DATA_WIDTH-1:0] rd_word;

  // Two-flop synchroniser on all connector inputs
  always_ff @(posedge clk) begin
    pins_meta <= pins_in;
    pins_sync <= pins_meta;
  end

  assign wr_hit = access.strobe && access.is_write;
  assign rd_hit = access.strobe && !access.is_write;

  // Control bits, each guarded by the byte lane that holds it
  always_ff @(posedge clk) begin
    if (rst) begin
      scl_out    <= 1'b1;
      sda_out    <= 1'b1;
      tx_disable <= 1'b0;
    end else if (wr_hit) begin
      case (access.word)
        sfp_mgmt_pkg::I2C_CTRL_W: begin
          if (access.wstrb[sfp_mgmt_pkg::SCL_OUT_BIT / 8]) begin
            scl_out <= access.wdata[sfp_mgmt_pkg::SCL_OUT_BIT];
          end
          if (access.wstrb[sfp_mgmt_pkg::SDA_OUT_BIT / 8]) begin
            sda_out <= access.wdata[sfp_mgmt_pkg::SDA_OUT_BIT];
          end
        end
        sfp_mgmt_pkg::GPIO_CTRL_W: begin
          if (access.wstrb[sfp_mgmt_pkg::TX_DISABLE_BIT / 8]) begin
            tx_disable <= access.wdata[sfp_mgmt_pkg::TX_DISABLE_BIT];
          end
        end
        default: begin
          // Read-only words, write is acked and dropped
        end
      endcase
    end
  end

  always_comb begin
    rd_word = '0;
    case (access.word)
      sfp_mgmt_pkg::I2C_TYPE_W:  rd_word = sfp_mgmt_pkg::I2C_TYPE;
      sfp_mgmt_pkg::I2C_VER_W:   rd_word = sfp_mgmt_pkg::RB_VERSION;
      sfp_mgmt_pkg::I2C_NEXT_W:  rd_word = GPIO_BASE;
      sfp_mgmt_pkg::I2C_CTRL_W: begin
        rd_word[sfp_mgmt_pkg::SCL_IN_BIT]  = pins_sync.scl;
        rd_word[sfp_mgmt_pkg::SCL_OUT_BIT] = scl_out;
        rd_word[sfp_mgmt_pkg::SDA_IN_BIT]  = pins_sync.sda;
        rd_word[sfp_mgmt_pkg::SDA_OUT_BIT] = sda_out;
      end
      sfp_mgmt_pkg::GPIO_TYPE_W: rd_word = sfp_mgmt_pkg::GPIO_TYPE;
      sfp_mgmt_pkg::GPIO_VER_W:  rd_word = sfp_mgmt_pkg::RB_VERSION;
      sfp_mgmt_pkg::GPIO_NEXT_W: rd_word = NEXT_CAGE_BASE;
      sfp_mgmt_pkg::GPIO_CTRL_W: begin
        rd_word[sfp_mgmt_pkg::MOD_PRESENT_BIT] = !pins_sync.mod_abs;
        rd_word[sfp_mgmt_pkg::TX_FAULT_BIT]    = pins_sync.tx_fault;
        rd_word[sfp_mgmt_pkg::RX_LOS_BIT]      = pins_sync.rx_los;
        rd_word[sfp_mgmt_pkg::TX_DISABLE_BIT]  = tx_disable;
      end
      default: rd_word = '0;
    endcase
  end

  // Idle cycles return zero data so the merge can OR all cages
  always_ff @(posedge clk) begin
    if (rst) begin
      rsp <= '0;
    end else begin
      rsp.wr_ack <= wr_hit;
      rsp.rd_ack <= rd_hit;
      rsp.rdata  <= rd_hit ? rd_word : '0;
    end
  end

  // Open drain, line released when the output bit is 1
  assign pins_out.tx_disable    = tx_disable;
  assign pins_out.scl_drive_low = !scl_out;
  assign pins_out.sda_drive_low = !sda_out;

  assign status.present    = !pins_sync.mod_abs;
  assign status.tx_fault   = pins_sync.tx_fault;
  assign status.rx_los     = pins_sync.rx_los;
  assign status.tx_disable = tx_disable;

endmodule

// ==== source/sfp_mgmt_pkg.sv ====
// Register map constants, word offset enum and packed bus structs for SFP management
package sfp_mgmt_pkg;

  localparam int NUM_CAGES = 4;
  localparam int ADDR_WIDTH = 16;
  localparam int DATA_WIDTH = 32;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;

  // Register chain layout, byte addresses
  localparam logic [ADDR_WIDTH-1:0] RB_BASE_ADDR = 16'h1000;
  localparam logic [ADDR_WIDTH-1:0] CAGE_STRIDE = 16'h20;
  localparam logic [ADDR_WIDTH-1:0] GPIO_BLOCK_OFFSET = 16'h10;
  localparam logic [ADDR_WIDTH-1:0] MAP_SIZE = ADDR_WIDTH'(NUM_CAGES) * CAGE_STRIDE;

  // Address slicing inside the mapped window
  localparam int WORD_LSB = 2;
  localparam int WORD_WIDTH = 3;
  localparam int CAGE_LSB = WORD_LSB + WORD_WIDTH;
  localparam int CAGE_IDX_WIDTH = (NUM_CAGES > 1) ? $clog2(NUM_CAGES) : 1;

  // Block identification words
  localparam logic [DATA_WIDTH-1:0] I2C_TYPE = 32'h0000C110;
  localparam logic [DATA_WIDTH-1:0] GPIO_TYPE = 32'h0000C101;
  localparam logic [DATA_WIDTH-1:0] RB_VERSION = 32'h00000100;

  // I2C control word bits
  localparam int SCL_IN_BIT = 0;
  localparam int SCL_OUT_BIT = 1;
  localparam int SDA_IN_BIT = 8;
  localparam int SDA_OUT_BIT = 9;

  // Transceiver GPIO control word bits
  localparam int MOD_PRESENT_BIT = 0;
  localparam int TX_FAULT_BIT = 1;
  localparam int RX_LOS_BIT = 2;
  localparam int TX_DISABLE_BIT = 5;

  // Word offsets within one cage, I2C block first
  typedef enum logic [WORD_WIDTH-1:0] {
    I2C_TYPE_W  = 3'd0,
    I2C_VER_W   = 3'd1,
    I2C_NEXT_W  = 3'd2,
    I2C_CTRL_W  = 3'd3,
    GPIO_TYPE_W = 3'd4,
    GPIO_VER_W  = 3'd5,
    GPIO_NEXT_W = 3'd6,
    GPIO_CTRL_W = 3'd7
  } reg_word_e;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] wdata;
    logic [STRB_WIDTH-1:0] wstrb;
    logic                  wr_en;
    logic                  rd_en;
  } reg_req_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] rdata;
    logic                  wr_ack;
    logic                  rd_ack;
  } reg_rsp_t;

  // Single-cycle access to one cage
  typedef struct packed {
    logic                  strobe;
    logic                  is_write;
    reg_word_e             word;
    logic [DATA_WIDTH-1:0] wdata;
    logic [STRB_WIDTH-1:0] wstrb;
  } cage_access_t;

  // Raw levels seen at the cage connector
  typedef struct packed {
    logic tx_fault;
    logic rx_los;
    logic mod_abs;
    logic scl;
    logic sda;
  } cage_pins_in_t;

  typedef struct packed {
    logic tx_disable;
    logic scl_drive_low;
    logic sda_drive_low;
  } cage_pins_out_t;

  typedef struct packed {
    logic present;
    logic tx_fault;
    logic rx_los;
    logic tx_disable;
  } cage_status_t;

endpackage

// ==== source/sfp_mgmt_top.sv ====
// Top level with register decoder, one register block per SFP cage and response merge
module sfp_mgmt_top (
  input  logic                                                        clk,
  input  logic                                                        rst,
  input  sfp_mgmt_pkg::reg_req_t                                      req,
  output sfp_mgmt_pkg::reg_rsp_t                                      rsp,
  input  sfp_mgmt_pkg::cage_pins_in_t [sfp_mgmt_pkg::NUM_CAGES-1:0]   pins_in,
  output sfp_mgmt_pkg::cage_pins_out_t [sfp_mgmt_pkg::NUM_CAGES-1:0]  pins_out,
  output logic [sfp_mgmt_pkg::NUM_CAGES-1:0]                          led,
  output logic                                                        alarm
);

  sfp_mgmt_pkg::cage_access_t [sfp_mgmt_pkg::NUM_CAGES-1:0]  access;
  sfp_mgmt_pkg::reg_rsp_t [sfp_mgmt_pkg::NUM_CAGES-1:0]      cage_rsp;
  sfp_mgmt_pkg::cage_status_t [sfp_mgmt_pkg::NUM_CAGES-1:0]  cage_status;

  sfp_reg_decode decode_inst (
    .clk    (clk),
    .rst    (rst),
    .req    (req),
    .access (access)
  );

  for (genvar i = 0; i < sfp_mgmt_pkg::NUM_CAGES; i++) begin : g_cage
    sfp_cage_regs #(
      .CAGE_INDEX (i)
    ) cage_inst (
      .clk      (clk),
      .rst      (rst),
      .access   (access[i]),
      .pins_in  (pins_in[i]),
      .pins_out (pins_out[i]),
      .rsp      (cage_rsp[i]),
      .status   (cage_status[i])
    );
  end

  sfp_reg_merge merge_inst (
    .clk         (clk),
    .rst         (rst),
    .cage_rsp    (cage_rsp),
    .cage_status (cage_status),
    .rsp         (rsp),
    .led         (led),
    .alarm       (alarm)
  );

endmodule

// ==== source/sfp_reg_decode.sv ====
// Address decoder that turns held host enables into one-shot per-cage access strobes
module sfp_reg_decode (
  input  logic                                                      clk,
  input  logic                                                      rst,
  input  sfp_mgmt_pkg::reg_req_t                                    req,
  output sfp_mgmt_pkg::cage_access_t [sfp_mgmt_pkg::NUM_CAGES-1:0]  access
);

  logic                                    armed;
  logic                                    req_active;
  logic                                    mapped;
  logic                                    fire;
  logic [sfp_mgmt_pkg::ADDR_WIDTH-1:0]     offset;
  logic [sfp_mgmt_pkg::CAGE_IDX_WIDTH-1:0] cage_idx;
  sfp_mgmt_pkg::reg_word_e                 word;

  assign req_active = req.wr_en | req.rd_en;

  // Offset from the start of the chain, low two bits never looked at
  assign offset = req.addr - sfp_mgmt_pkg::RB_BASE_ADDR;
  assign mapped = (req.addr >= sfp_mgmt_pkg::RB_BASE_ADDR) &&
                  (offset < sfp_mgmt_pkg::MAP_SIZE);

  assign cage_idx = offset[sfp_mgmt_pkg::CAGE_LSB +: sfp_mgmt_pkg::CAGE_IDX_WIDTH];
  assign word = sfp_mgmt_pkg::reg_word_e'(
                  offset[sfp_mgmt_pkg::WORD_LSB +: sfp_mgmt_pkg::WORD_WIDTH]);

  // One access per enable, mapped addresses only
  assign fire = armed && req_active && mapped;

  // Disarm on the first edge an enable is seen, rearm once both enables drop
  always_ff @(posedge clk) begin
    if (rst) begin
      armed <= 1'b1;
    end else if (armed && req_active) begin
      armed <= 1'b0;
    end else if (!req_active) begin
      armed <= 1'b1;
    end
  end

  always_comb begin
    for (int i = 0; i < sfp_mgmt_pkg::NUM_CAGES; i++) begin
      access[i].strobe   = fire && (int'(cage_idx) == i);
      access[i].is_write = req.wr_en;
      access[i].word     = word;
      access[i].wdata    = req.wdata;
      access[i].wstrb    = req.wstrb;
    end
  end

endmodule

// ==== source/sfp_reg_merge.sv ====
// Response combiner with output register, per-cage link LEDs and summary alarm
module sfp_reg_merge (
  input  logic                                                      clk,
  input  logic                                                      rst,
  input  sfp_mgmt_pkg::reg_rsp_t [sfp_mgmt_pkg::NUM_CAGES-1:0]      cage_rsp,
  input  sfp_mgmt_pkg::cage_status_t [sfp_mgmt_pkg::NUM_CAGES-1:0]  cage_status,
  output sfp_mgmt_pkg::reg_rsp_t                                    rsp,
  output logic [sfp_mgmt_pkg::NUM_CAGES-1:0]                        led,
  output logic                                                      alarm
);

  sfp_mgmt_pkg::reg_rsp_t                rsp_any;
  logic [sfp_mgmt_pkg::NUM_CAGES-1:0]    link_ok;
  logic [sfp_mgmt_pkg::NUM_CAGES-1:0]    cage_alarm;

  always_comb begin
    rsp_any = '0;
    for (int i = 0; i < sfp_mgmt_pkg::NUM_CAGES; i++) begin
      // At most one cage answers in a cycle
      rsp_any.rdata  = rsp_any.rdata | cage_rsp[i].rdata;
      rsp_any.wr_ack = rsp_any.wr_ack | cage_rsp[i].wr_ack;
      rsp_any.rd_ack = rsp_any.rd_ack | cage_rsp[i].rd_ack;

      link_ok[i] = cage_status[i].present && !cage_status[i].rx_los &&
                   !cage_status[i].tx_fault;

      // Disabled transmitters are expected to look faulty
      cage_alarm[i] = cage_status[i].present && !cage_status[i].tx_disable &&
                      (cage_status[i].tx_fault || cage_status[i].rx_los);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rsp   <= '0;
      led   <= '0;
      alarm <= 1'b0;
    end else begin
      rsp   <= rsp_any;
      led   <= link_ok;
      alarm <= |cage_alarm;
    end
  end

endmodule

// ==== sources.f ====
source/sfp_mgmt_pkg.sv
source/sfp_reg_decode.sv
source/sfp_cage_regs.sv
source/sfp_reg_merge.sv
source/sfp_mgmt_top.sv
verification/tb_clock.sv
verification/sfp_mgmt_tb.sv

// ==== verification/sfp_mgmt_tb.sv ====
// Testbench with board pin model, register reference model, compare task and test sequence
module sfp_mgmt_tb;

  localparam int NC = sfp_mgmt_pkg::NUM_CAGES;
  localparam int IDX_W = sfp_mgmt_pkg::CAGE_IDX_WIDTH;
  localparam int STRIDE = int'(sfp_mgmt_pkg::CAGE_STRIDE);
  localparam int BASE = int'(sfp_mgmt_pkg::RB_BASE_ADDR);
  localparam int ACK_LATENCY = 2;
  localparam int ACK_WAIT_LIMIT = 10;
  localparam int UNMAPPED_WAIT = 10;
  localparam int SETTLE_CYCLES = 4;
  localparam int RESET_CYCLES = 16;
  localparam int RANDOM_WRITES = 24;
  localparam int STATUS_ROUNDS = 8;
  // Header walk, unmapped probe, random writes, bit-bang, status rounds
  localparam int TOTAL_ACCESSES = 6 * NC + (3 + 2 * NC) + 2 * RANDOM_WRITES + 3 * NC +
                                  STATUS_ROUNDS * (1 + NC);
  localparam int TIMEOUT_CYCLES = 20 * TOTAL_ACCESSES + 200;

  typedef logic [IDX_W-1:0] cage_idx_t;

  // Bits the host has written into one cage
  typedef struct packed {
    logic scl_out;
    logic sda_out;
    logic tx_disable;
  } ctrl_model_t;

  // Levels the board applies to one cage
  typedef struct packed {
    logic scl_pull;
    logic sda_pull;
    logic mod_abs;
    logic tx_fault;
    logic rx_los;
  } pin_state_t;

  localparam ctrl_model_t RESET_CTRL = '{scl_out: 1'b1, sda_out: 1'b1, tx_disable: 1'b0};

  logic                                                 clk;
  logic                                                 rst;
  sfp_mgmt_pkg::reg_req_t                               req;
  sfp_mgmt_pkg::reg_rsp_t                               rsp;
  sfp_mgmt_pkg::cage_pins_in_t [NC-1:0]                 pins_in;
  sfp_mgmt_pkg::cage_pins_out_t [NC-1:0]                pins_out;
  logic [NC-1:0]                                        led;
  logic                                                 alarm;
  ctrl_model_t [NC-1:0]                                 ctrl_model;
  pin_state_t [NC-1:0]                                  pin_state;
  int                                                   seq_checks = 0;
  int                                                   seq_errors = 0;
  int                                                   read_checks = 0;
  int                                                   read_errors = 0;
  int                                                   cycle_count = 0;

  tb_clock clock_gen (
    .clk (clk)
  );

  sfp_mgmt_top dut (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .rsp      (rsp),
    .pins_in  (pins_in),
    .pins_out (pins_out),
    .led      (led),
    .alarm    (alarm)
  );

  // Open-drain lines resolve as a wired-AND of the DUT and the external pull-down
  always_comb begin
    for (int i = 0; i < NC; i++) begin
      pins_in[i].tx_fault = pin_state[i].tx_fault;
      pins_in[i].rx_los   = pin_state[i].rx_los;
      pins_in[i].mod_abs  = pin_state[i].mod_abs;
      pins_in[i].scl      = !pins_out[i].scl_drive_low && !pin_state[i].scl_pull;
      pins_in[i].sda      = !pins_out[i].sda_drive_low && !pin_state[i].sda_pull;
    end
  end

  task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                         input string what, inout int checks, inout int errors);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error at time %0t: %s, expected %h, got %h", $time, what, expected, actual);
    end
  endtask

  function automatic logic is_mapped(input logic [15:0] addr);
    int off;
    off = int'(addr) - BASE;
    return (off >= 0) && (off < NC * STRIDE);
  endfunction

  function automatic cage_idx_t cage_of(input logic [15:0] addr);
    return cage_idx_t'((int'(addr) - BASE) / STRIDE);
  endfunction

  function automatic int word_of(input logic [15:0] addr);
    return ((int'(addr) - BASE) % STRIDE) / 4;
  endfunction

  function automatic logic [15:0] word_addr(input int cage, input int word);
    return sfp_mgmt_pkg::RB_BASE_ADDR + 16'(cage * STRIDE + word * 4);
  endfunction

  function automatic logic [31:0] expected_read(input logic [15:0] addr,
                                                input ctrl_model_t [NC-1:0] ctrl,
                                                input pin_state_t [NC-1:0] pins);
    cage_idx_t   c;
    logic [31:0] cage_base;
    logic [31:0] d;
    c = cage_of(addr);
    cage_base = 32'(BASE + int'(c) * STRIDE);
    d = '0;
    case (word_of(addr))
      0: d = sfp_mgmt_pkg::I2C_TYPE;
      1, 5: d = sfp_mgmt_pkg::RB_VERSION;
      // GPIO block sits half a stride above the I2C block
      2: d = cage_base + 32'(STRIDE / 2);
      3: begin
        d[0] = ctrl[c].scl_out && !pins[c].scl_pull;
        d[1] = ctrl[c].scl_out;
        d[8] = ctrl[c].sda_out && !pins[c].sda_pull;
        d[9] = ctrl[c].sda_out;
      end
      4: d = sfp_mgmt_pkg::GPIO_TYPE;
      6: d = (int'(c) == NC - 1) ? 32'd0 : cage_base + 32'(STRIDE);
      7: begin
        d[0] = !pins[c].mod_abs;
        d[1] = pins[c].tx_fault;
        d[2] = pins[c].rx_los;
        d[5] = ctrl[c].tx_disable;
      end
      default: d = '0;
    endcase
    return d;
  endfunction

  // Every read response is checked against the model
  always @(negedge clk) begin
    if (!rst && rsp.rd_ack) begin
      compare(rsp.rdata, expected_read(req.addr, ctrl_model, pin_state), "read data",
              read_checks, read_errors);
    end
  end

  task automatic bus_access(input logic [15:0] addr, input logic wr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, input logic expect_ack,
                            output logic [31:0] rdata);
    int waits;
    int acks;
    int extra;
    waits = 0;
    acks = 0;
    extra = 0;
    rdata = '0;
    @(posedge clk);
    req.addr  <= addr;
    req.wdata <= wdata;
    req.wstrb <= wstrb;
    req.wr_en <= wr;
    req.rd_en <= !wr;
    if (expect_ack) begin
      while (acks == 0 && waits < ACK_WAIT_LIMIT) begin
        @(negedge clk);
        waits++;
        if (rsp.wr_ack || rsp.rd_ack) begin
          acks++;
          rdata = rsp.rdata;
          compare(32'(rsp.wr_ack), 32'(wr), "ack type", seq_checks, seq_errors);
        end
      end
      compare(32'(acks), 32'd1, "ack received", seq_checks, seq_errors);
      // First negedge comes before the edge that sees the enable
      if (acks != 0) begin
        compare(32'(waits - 1), 32'(ACK_LATENCY), "ack latency", seq_checks, seq_errors);
      end
    end else begin
      repeat (UNMAPPED_WAIT) begin
        @(negedge clk);
        if (rsp.wr_ack || rsp.rd_ack) begin
          acks++;
        end
      end
      compare(32'(acks), 32'd0, "ack on unmapped address", seq_checks, seq_errors);
    end
    @(posedge clk);
    req.wr_en <= 1'b0;
    req.rd_en <= 1'b0;
    repeat (2) begin
      @(negedge clk);
      if (rsp.wr_ack || rsp.rd_ack) begin
        extra++;
      end
    end
    compare(32'(extra), 32'd0, "extra ack", seq_checks, seq_errors);
  endtask

  task automatic read_word(input logic [15:0] addr, output logic [31:0] data);
    bus_access(addr, 1'b0, 32'd0, 4'd0, is_mapped(addr), data);
  endtask

  task automatic write_word(input logic [15:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
    logic [31:0] ignored;
    cage_idx_t   c;
    bus_access(addr, 1'b1, data, strb, is_mapped(addr), ignored);
    if (is_mapped(addr)) begin
      c = cage_of(addr);
      case (word_of(addr))
        3: begin
          if (strb[0]) begin
            ctrl_model[c].scl_out = data[1];
          end
          if (strb[1]) begin
            ctrl_model[c].sda_out = data[9];
          end
        end
        7: begin
          if (strb[0]) begin
            ctrl_model[c].tx_disable = data[5];
          end
        end
        default: begin
        end
      endcase
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic pin_drive_check();
    ctrl_model_t m;
    for (int i = 0; i < NC; i++) begin
      m = ctrl_model[cage_idx_t'(i)];
      compare(32'(pins_out[cage_idx_t'(i)]), 32'({m.tx_disable, !m.scl_out, !m.sda_out}),
              "pins_out", seq_checks, seq_errors);
    end
  endtask

  task automatic status_check();
    logic [NC-1:0] exp_led;
    logic          exp_alarm;
    pin_state_t    p;
    exp_alarm = 1'b0;
    for (int i = 0; i < NC; i++) begin
      p = pin_state[cage_idx_t'(i)];
      exp_led[i] = !p.mod_abs && !p.rx_los && !p.tx_fault;
      if (!p.mod_abs && !ctrl_model[cage_idx_t'(i)].tx_disable && (p.tx_fault || p.rx_los)) begin
        exp_alarm = 1'b1;
      end
    end
    compare(32'(led), 32'(exp_led), "led", seq_checks, seq_errors);
    compare(32'(alarm), 32'(exp_alarm), "alarm", seq_checks, seq_errors);
  endtask

  function automatic int total_errors();
    return seq_errors + read_errors;
  endfunction

  task automatic report_test(input string name, input int errors_before);
    $display("%s: finished with %0d errors", name, total_errors() - errors_before);
  endtask

  task automatic reset_values();
    @(negedge clk);
    compare(rsp.rdata, 32'd0, "rdata after reset", seq_checks, seq_errors);
    compare(32'({rsp.wr_ack, rsp.rd_ack}), 32'd0, "acks after reset", seq_checks, seq_errors);
    compare(32'(led), 32'd0, "led after reset", seq_checks, seq_errors);
    compare(32'(alarm), 32'd0, "alarm after reset", seq_checks, seq_errors);
    pin_drive_check();
  endtask

  task automatic walk_header_chain();
    logic [15:0] addr;
    logic [31:0] type_word;
    logic [31:0] ver_word;
    logic [31:0] next_word;
    int          blocks;
    addr = sfp_mgmt_pkg::RB_BASE_ADDR;
    blocks = 0;
    while (addr != 16'd0 && blocks < 2 * NC) begin
      read_word(addr, type_word);
      read_word(addr + 16'd4, ver_word);
      read_word(addr + 16'd8, next_word);
      compare(type_word, (blocks % 2 == 0) ? 32'h0000C110 : 32'h0000C101, "block type",
              seq_checks, seq_errors);
      compare(ver_word, 32'h00000100, "block version", seq_checks, seq_errors);
      addr = next_word[15:0];
      blocks++;
    end
    compare(32'(blocks), 32'(2 * NC), "blocks in chain", seq_checks, seq_errors);
    compare(32'(addr), 32'd0, "chain end pointer", seq_checks, seq_errors);
  endtask

  task automatic probe_unmapped();
    logic [31:0] data;
    write_word(16'h0FFC, 32'hFFFF_FFFF, 4'hF);
    read_word(16'h1080, data);
    // Would alias cage 0 GPIO control if the window wrapped
    write_word(16'h109C, 32'hFFFF_FFFF, 4'hF);
    pin_drive_check();
    for (int i = 0; i < NC; i++) begin
      read_word(word_addr(i, 3), data);
      read_word(word_addr(i, 7), data);
    end
  endtask

  task automatic random_control_writes();
    logic [31:0] data;
    logic [15:0] addr;
    for (int n = 0; n < RANDOM_WRITES; n++) begin
      addr = word_addr(int'($urandom % NC), ($urandom % 2 == 0) ? 3 : 7);
      write_word(addr, $urandom, 4'($urandom));
      pin_drive_check();
      read_word(addr, data);
    end
  endtask

  task automatic i2c_bit_bang();
    logic [31:0] data;
    for (int i = 0; i < NC; i++) begin
      @(posedge clk);
      pin_state[cage_idx_t'(i)].scl_pull <= 1'b1;
      pin_state[cage_idx_t'(i)].sda_pull <= 1'b1;
      write_word(word_addr(i, 3), 32'h0000_0202, 4'b0011);
      pin_drive_check();
      wait_cycles(SETTLE_CYCLES);
      read_word(word_addr(i, 3), data);
      compare(32'({data[8], data[0]}), 32'd0, "lines with pull-down", seq_checks, seq_errors);
      @(posedge clk);
      pin_state[cage_idx_t'(i)].scl_pull <= 1'b0;
      pin_state[cage_idx_t'(i)].sda_pull <= 1'b0;
      wait_cycles(SETTLE_CYCLES);
      read_word(word_addr(i, 3), data);
      compare(32'({data[8], data[0]}), 32'd3, "released lines", seq_checks, seq_errors);
    end
  endtask

  task automatic gpio_status();
    logic [31:0] data;
    for (int r = 0; r < STATUS_ROUNDS; r++) begin
      @(posedge clk);
      for (int i = 0; i < NC; i++) begin
        pin_state[cage_idx_t'(i)].mod_abs  <= 1'($urandom);
        pin_state[cage_idx_t'(i)].tx_fault <= 1'($urandom);
        pin_state[cage_idx_t'(i)].rx_los   <= 1'($urandom);
      end
      write_word(word_addr(int'($urandom % NC), 7), {26'd0, 1'($urandom), 5'd0}, 4'b0001);
      wait_cycles(SETTLE_CYCLES);
      status_check();
      for (int i = 0; i < NC; i++) begin
        read_word(word_addr(i, 7), data);
      end
    end
  endtask

  initial begin
    int errs;
    void'($urandom(8));
    rst <= 1'b1;
    req <= '0;
    pin_state <= '0;
    ctrl_model = {NC{RESET_CTRL}};
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    errs = total_errors();
    reset_values();
    report_test("reset values", errs);
    errs = total_errors();
    walk_header_chain();
    report_test("header chain", errs);
    errs = total_errors();
    probe_unmapped();
    report_test("unmapped addresses", errs);
    errs = total_errors();
    random_control_writes();
    report_test("random control writes", errs);
    errs = total_errors();
    i2c_bit_bang();
    report_test("i2c bit-bang", errs);
    errs = total_errors();
    gpio_status();
    report_test("gpio inputs and status", errs);
    $display("Checks: %0d, errors: %0d", seq_checks + read_checks, total_errors());
    if (total_errors() == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Test failed");
    $finish;
  end

endmodule

// ==== verification/tb_clock.sv ====
// Free-running testbench clock with a period of 10 time units
module tb_clock #(
  parameter int HALF_PERIOD = 5
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

endmodule
